// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --assert --timing --timescale 1ns/1ps
TOP       ?= int_pipe_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard test/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx 'Test OK' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
+incdir+test
verilog/core_pkg.sv
verilog/register_file.sv
verilog/inst_decoder.sv
verilog/alu_stage.sv
verilog/int_pipe_top.sv
test/int_pipe_tb.sv

// ==== test/int_pipe_model.svh ====
`ifndef INT_PIPE_MODEL_SVH
`define INT_PIPE_MODEL_SVH

// RV32I major opcodes and the alternate funct7 (sub / sra)
localparam logic [6:0] opc_op_imm = 7'b0010011;
localparam logic [6:0] opc_op = 7'b0110011;
localparam logic [6:0] opc_lui = 7'b0110111;
localparam logic [6:0] opc_auipc = 7'b0010111;
localparam logic [6:0] f7_alt = 7'b0100000;

// register state as seen by accepted and by retired instructions
logic [31:0] spec_regs [32];
logic [31:0] ret_regs [32];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'b000: r = alt ? a - b : a + b;
    3'b001: r = a << b[4:0];
    3'b010: r = {31'b0, $signed(a) < $signed(b)};
    3'b011: r = {31'b0, a < b};
    3'b100: r = a ^ b;
    3'b101: begin
      // arithmetic shift kept apart so it stays signed
      if (alt) begin
        r = $signed(a) >>> b[4:0];
      end else begin
        r = a >> b[4:0];
      end
    end
    3'b110: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// result of one instruction, zero when the encoding is illegal
function automatic logic [31:0] model_result(input logic [31:0] inst, input logic [31:0] pc,
                                             input logic [31:0] v1, input logic [31:0] v2,
                                             output logic legal);
  logic [6:0] f7;
  logic [2:0] f3;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] r;
  f7 = inst[31:25];
  f3 = inst[14:12];
  imm_i = {{20{inst[31]}}, inst[31:20]};
  imm_u = {inst[31:12], 12'b0};
  legal = 1'b1;
  r = '0;
  case (inst[6:0])
    opc_op_imm: begin
      if (f3 == 3'b001) begin
        legal = f7 == 7'b0;
      end else if (f3 == 3'b101) begin
        legal = f7 == 7'b0 || f7 == f7_alt;
      end
      r = alu_ref(f3, f3 == 3'b101 && f7 == f7_alt, v1, imm_i);
    end
    opc_op: begin
      legal = f7 == 7'b0 || (f7 == f7_alt && (f3 == 3'b000 || f3 == 3'b101));
      r = alu_ref(f3, f7 == f7_alt, v1, v2);
    end
    opc_lui: r = imm_u;
    opc_auipc: r = pc + imm_u;
    default: legal = 1'b0;
  endcase
  return legal ? r : 32'b0;
endfunction

`endif

// ==== test/int_pipe_tb.sv ====
module int_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_insts = 600;
  localparam int num_preload = 7;
  localparam int stim_limit = 20000;
  localparam int drain_limit = 100;

  logic clock;
  logic reset;
  logic flush;
  logic in_valid;
  logic in_ready;
  logic [31:0] in_pc;
  logic [31:0] in_inst;
  logic retire_valid;
  logic retire_ready;
  logic [31:0] retire_pc;
  logic [4:0] retire_rd;
  logic [31:0] retire_value;
  logic retire_illegal;

  logic [31:0] lfsr_state;
  logic [31:0] next_pc;
  int accepted;
  int retired;
  int mismatches;
  int other_errors;
  logic hold_pending;
  logic [31:0] held_pc;
  logic [4:0] held_rd;
  logic [31:0] held_value;
  logic held_illegal;

  // expected retire records, oldest first
  logic [31:0] exp_pc [$];
  logic [4:0] exp_rd [$];
  logic [31:0] exp_value [$];
  logic exp_illegal [$];

  `include "int_pipe_model.svh"

  int_pipe_top u_dut (.*);

  always #50 clock = ~clock;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // registers limited to x0..x7 so hazards come often
  function automatic logic [31:0] make_inst();
    logic [2:0] kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [11:0] imm;
    logic [31:0] word;
    kind = 3'(rand_bits(3));
    rd = 5'(rand_bits(3));
    rs1 = 5'(rand_bits(3));
    rs2 = 5'(rand_bits(3));
    f3 = 3'(rand_bits(3));
    case (kind)
      3'd0, 3'd1, 3'd2: begin
        imm = 12'(rand_bits(12));
        if (rand_bits(3) == 0) begin
          // upper bits stay random, so a shift may come out illegal
        end else if (f3 == 3'b001) begin
          imm[11:5] = 7'b0;
        end else if (f3 == 3'b101) begin
          imm[11:5] = rand_bits(1) != 0 ? f7_alt : 7'b0;
        end
        word = enc_i(imm, rs1, f3, rd, opc_op_imm);
      end
      3'd3, 3'd4, 3'd5: word = enc_r(rand_bits(1) != 0 ? f7_alt : 7'b0, rs2, rs1, f3, rd, opc_op);
      3'd6: word = enc_u(20'(rand_bits(20)), rd, rand_bits(1) != 0 ? opc_lui : opc_auipc);
      default: begin
        // either an unknown major opcode or an RV32M encoding
        if (rand_bits(1) != 0) begin
          word = rand_bits(32);
          word[6:5] = 2'b11;
        end else begin
          word = enc_r(7'b0000001, rs2, rs1, f3, rd, opc_op);
        end
      end
    endcase
    return word;
  endfunction

  task automatic drive_random();
    if (accepted < num_preload) begin
      // give x1..x7 known values first
      in_valid = 1'b1;
      in_inst = enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'(accepted + 1), opc_op_imm);
      flush = 1'b0;
    end else begin
      in_valid = rand_bits(2) != 0;
      in_inst = make_inst();
      flush = retired >= num_preload && rand_bits(6) == 0;
    end
    in_pc = next_pc;
    retire_ready = rand_bits(2) != 0;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic accept_inst(input logic [31:0] pc, input logic [31:0] inst);
    logic legal;
    logic [31:0] value;
    logic [4:0] rd;
    value = model_result(inst, pc, spec_regs[inst[19:15]], spec_regs[inst[24:20]], legal);
    rd = legal ? inst[11:7] : 5'd0;
    exp_pc.push_back(pc);
    exp_rd.push_back(rd);
    exp_value.push_back(value);
    exp_illegal.push_back(!legal);
    if (rd != 0) begin
      spec_regs[rd] = value;
    end
    accepted++;
    next_pc = pc + 4;
  endtask

  task automatic collect_retire();
    logic [4:0] rd;
    logic [31:0] value;
    logic illegal;
    assert (exp_pc.size() != 0) else begin
      other_errors++;
      $display("retire handshake at %0t ns with no instruction outstanding", $time);
    end
    if (exp_pc.size() != 0) begin
      rd = exp_rd.pop_front();
      value = exp_value.pop_front();
      illegal = exp_illegal.pop_front();
      check_value("retire_pc", retire_pc, exp_pc.pop_front());
      check_value("retire_rd", 32'(retire_rd), 32'(rd));
      check_value("retire_value", retire_value, value);
      check_value("retire_illegal", 32'(retire_illegal), 32'(illegal));
      if (!illegal && rd != 0) begin
        ret_regs[rd] = value;
      end
      retired++;
    end
  endtask

  // in-flight work never wrote the register file, so fall back to retired state
  task automatic drop_in_flight();
    exp_pc.delete();
    exp_rd.delete();
    exp_value.delete();
    exp_illegal.delete();
    spec_regs = ret_regs;
  endtask

  task automatic finish_run();
    $display("checked %0d retired results: %0d mismatches, %0d other errors",
             retired, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  always @(posedge clock) begin
    if (!reset) begin
      if (hold_pending) begin
        assert (retire_valid === 1'b1) else begin
          other_errors++;
          $display("retire_valid dropped at %0t ns while the retire port was stalled", $time);
        end
        check_value("retire_pc held", retire_pc, held_pc);
        check_value("retire_rd held", 32'(retire_rd), 32'(held_rd));
        check_value("retire_value held", retire_value, held_value);
        check_value("retire_illegal held", 32'(retire_illegal), 32'(held_illegal));
      end
      hold_pending = retire_valid && !retire_ready && !flush;
      held_pc = retire_pc;
      held_rd = retire_rd;
      held_value = retire_value;
      held_illegal = retire_illegal;
      check_value("in_ready", 32'(in_ready), 32'(!flush && !(retire_valid && !retire_ready)));
      // a retire on the flush edge still commits
      if (retire_valid && retire_ready) begin
        collect_retire();
      end
      if (flush) begin
        drop_in_flight();
      end
      if (in_valid && in_ready) begin
        accept_inst(in_pc, in_inst);
      end
    end
  end

  initial begin
    int cycles;
    clock = 1'b0;
    reset = 1'b1;
    flush = 1'b0;
    in_valid = 1'b0;
    in_pc = '0;
    in_inst = '0;
    retire_ready = 1'b0;
    lfsr_state = 32'hd4a02307;
    next_pc = 32'h0000_1000;
    accepted = 0;
    retired = 0;
    mismatches = 0;
    other_errors = 0;
    hold_pending = 1'b0;
    foreach (spec_regs[i]) begin
      spec_regs[i] = '0;
      ret_regs[i] = '0;
    end
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    assert (in_ready === 1'b1 && retire_valid === 1'b0) else begin
      other_errors++;
      $display("port state after reset is wrong: in_ready %b retire_valid %b",
               in_ready, retire_valid);
    end
    cycles = 0;
    while (accepted < num_insts && cycles < stim_limit) begin
      drive_random();
      @(negedge clock);
      cycles++;
    end
    in_valid = 1'b0;
    flush = 1'b0;
    retire_ready = 1'b1;
    if (accepted < num_insts) begin
      other_errors++;
      $display("timeout: only %0d of %0d instructions were accepted", accepted, num_insts);
    end else begin
      cycles = 0;
      while ((exp_pc.size() != 0 || retire_valid) && cycles < drain_limit) begin
        @(negedge clock);
        cycles++;
      end
      if (exp_pc.size() != 0 || retire_valid) begin
        other_errors++;
        $display("timeout: %0d results never left the retire port", exp_pc.size());
      end
    end
    finish_run();
  end

endmodule

// ==== verilog/alu_stage.sv ====
module alu_stage (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic dec_valid,
  input  logic [core_pkg::xlen-1:0] dec_pc,
  input  logic [core_pkg::reg_addr_width-1:0] dec_rd,
  input  logic dec_wen,
  input  logic dec_illegal,
  input  core_pkg::alu_op_e dec_alu_op,
  input  logic [core_pkg::xlen-1:0] dec_imm,
  input  logic dec_use_imm,
  input  logic dec_use_pc,
  input  core_pkg::fwd_sel_e fwd_a,
  input  core_pkg::fwd_sel_e fwd_b,
  input  logic [core_pkg::xlen-1:0] rdata1,
  input  logic [core_pkg::xlen-1:0] rdata2,
  output logic [core_pkg::reg_addr_width-1:0] exec_rd,
  output logic exec_wen,
  output logic stall,
  output logic wr_en,
  output logic [core_pkg::reg_addr_width-1:0] wr_addr,
  output logic [core_pkg::xlen-1:0] wr_data,
  output logic retire_valid,
  input  logic retire_ready,
  output logic [core_pkg::xlen-1:0] retire_pc,
  output logic [core_pkg::reg_addr_width-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0] retire_value,
  output logic retire_illegal,
  output logic retire_wen
);

  logic ex_valid;
  logic ex_wen;
  logic ex_illegal;
  logic ret_wen;
  logic [core_pkg::xlen-1:0] ex_pc;
  logic [core_pkg::reg_addr_width-1:0] ex_rd;
  core_pkg::alu_op_e ex_op;
  logic [core_pkg::xlen-1:0] ex_a;
  logic [core_pkg::xlen-1:0] ex_b;
  logic [core_pkg::xlen-1:0] src_a;
  logic [core_pkg::xlen-1:0] src_b;
  logic [core_pkg::xlen-1:0] alu_result;

  function automatic logic [core_pkg::xlen-1:0] pick_source(
    input core_pkg::fwd_sel_e sel,
    input logic [core_pkg::xlen-1:0] from_exec,
    input logic [core_pkg::xlen-1:0] from_retire,
    input logic [core_pkg::xlen-1:0] from_rf
  );
    logic [core_pkg::xlen-1:0] value;
    case (sel)
      core_pkg::fwd_exec: value = from_exec;
      core_pkg::fwd_retire: value = from_retire;
      default: value = from_rf;
    endcase
    return value;
  endfunction

  assign src_a = pick_source(fwd_a, alu_result, retire_value, rdata1);
  assign src_b = pick_source(fwd_b, alu_result, retire_value, rdata2);

  // whole pipe holds while the retire slot is full and not taken
  assign stall = retire_valid && !retire_ready;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      ex_valid <= 1'b0;
      ex_wen <= 1'b0;
      ex_illegal <= 1'b0;
      retire_valid <= 1'b0;
      ret_wen <= 1'b0;
      retire_illegal <= 1'b0;
    end else if (!stall) begin
      ex_valid <= dec_valid;
      ex_wen <= dec_wen;
      ex_illegal <= dec_illegal;
      retire_valid <= ex_valid;
      ret_wen <= ex_valid && ex_wen;
      retire_illegal <= ex_illegal;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      ex_pc <= dec_pc;
      ex_rd <= dec_rd;
      ex_op <= dec_alu_op;
      ex_a <= dec_use_pc ? dec_pc : src_a;
      ex_b <= dec_use_imm ? dec_imm : src_b;
      retire_pc <= ex_pc;
      retire_rd <= ex_rd;
      retire_value <= ex_illegal ? '0 : alu_result;
    end
  end

  always_comb begin
    case (ex_op)
      core_pkg::alu_add: alu_result = ex_a + ex_b;
      core_pkg::alu_sub: alu_result = ex_a - ex_b;
      core_pkg::alu_sll: alu_result = ex_a << ex_b[4:0];
      core_pkg::alu_slt: alu_result = {{(core_pkg::xlen-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
      core_pkg::alu_sltu: alu_result = {{(core_pkg::xlen-1){1'b0}}, ex_a < ex_b};
      core_pkg::alu_xor: alu_result = ex_a ^ ex_b;
      core_pkg::alu_srl: alu_result = ex_a >> ex_b[4:0];
      core_pkg::alu_sra: alu_result = $unsigned($signed(ex_a) >>> ex_b[4:0]);
      core_pkg::alu_or: alu_result = ex_a | ex_b;
      core_pkg::alu_and: alu_result = ex_a & ex_b;
      core_pkg::alu_pass_b: alu_result = ex_b;
      default: alu_result = '0;
    endcase
  end

  assign exec_rd = ex_rd;
  assign exec_wen = ex_valid && ex_wen;
  assign retire_wen = retire_valid && ret_wen;

  // register write happens on the retire handshake
  assign wr_en = retire_valid && retire_ready && ret_wen;
  assign wr_addr = retire_rd;
  assign wr_data = retire_value;

  retire_held_under_stall: assert property (
    @(posedge clock) disable iff (reset || flush)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
      && $stable(retire_rd) && $stable(retire_value) && $stable(retire_illegal)
  );

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

  // datapath and register index widths
  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  // funct7 patterns for the base and alternate (sub / sra) forms
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // major opcodes handled by this pipeline
  typedef enum logic [6:0] {
    op_imm = 7'b0010011,
    op_reg = 7'b0110011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    // lui result, second operand straight through
    alu_pass_b = 4'd10
  } alu_op_e;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    fwd_none   = 2'd0,
    fwd_exec   = 2'd1,
    fwd_retire = 2'd2
  } fwd_sel_e;

endpackage

// ==== verilog/inst_decoder.sv ====
module inst_decoder (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic stall,
  input  logic in_valid,
  output logic in_ready,
  input  logic [core_pkg::xlen-1:0] in_pc,
  input  logic [core_pkg::xlen-1:0] in_inst,
  output logic [core_pkg::reg_addr_width-1:0] rs1,
  output logic [core_pkg::reg_addr_width-1:0] rs2,
  input  logic [core_pkg::reg_addr_width-1:0] exec_rd,
  input  logic exec_wen,
  input  logic [core_pkg::reg_addr_width-1:0] retire_rd,
  input  logic retire_wen,
  output logic dec_valid,
  output logic dec_wen,
  output logic dec_illegal,
  output logic dec_use_imm,
  output logic dec_use_pc,
  output logic [core_pkg::xlen-1:0] dec_pc,
  output logic [core_pkg::xlen-1:0] dec_imm,
  output logic [core_pkg::reg_addr_width-1:0] dec_rd,
  output core_pkg::alu_op_e dec_alu_op,
  output core_pkg::fwd_sel_e fwd_a,
  output core_pkg::fwd_sel_e fwd_b
);

  logic valid_q;
  logic [core_pkg::xlen-1:0] inst_q;
  logic [core_pkg::xlen-1:0] pc_q;
  logic accept;
  core_pkg::opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [core_pkg::reg_addr_width-1:0] rd_field;
  logic [core_pkg::xlen-1:0] i_imm;
  logic [core_pkg::xlen-1:0] u_imm;
  logic legal;
  logic use_imm;
  logic use_pc;
  logic is_u_type;
  core_pkg::alu_op_e alu_op;

  // funct3 to alu operation, alt picks sub / sra
  function automatic core_pkg::alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
    core_pkg::alu_op_e op;
    case (f3)
      3'b000: op = alt ? core_pkg::alu_sub : core_pkg::alu_add;
      3'b001: op = core_pkg::alu_sll;
      3'b010: op = core_pkg::alu_slt;
      3'b011: op = core_pkg::alu_sltu;
      3'b100: op = core_pkg::alu_xor;
      3'b101: op = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
      3'b110: op = core_pkg::alu_or;
      default: op = core_pkg::alu_and;
    endcase
    return op;
  endfunction

  // youngest producer wins, x0 is never forwarded
  function automatic core_pkg::fwd_sel_e fwd_select(
    input logic [core_pkg::reg_addr_width-1:0] rs,
    input logic [core_pkg::reg_addr_width-1:0] ex_rd,
    input logic ex_wen,
    input logic rt_rd_en,
    input logic [core_pkg::reg_addr_width-1:0] rt_rd
  );
    core_pkg::fwd_sel_e sel;
    sel = core_pkg::fwd_none;
    if (rs != '0 && ex_wen && rs == ex_rd) begin
      sel = core_pkg::fwd_exec;
    end else if (rs != '0 && rt_rd_en && rs == rt_rd) begin
      sel = core_pkg::fwd_retire;
    end
    return sel;
  endfunction

  assign in_ready = !stall && !flush;
  assign accept = in_valid && in_ready;

  // instruction register, a bubble loads all zeros
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid_q <= 1'b0;
      inst_q <= '0;
    end else if (!stall) begin
      valid_q <= accept;
      inst_q <= accept ? in_inst : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pc_q <= in_pc;
    end
  end

  assign opcode = core_pkg::opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rd_field = inst_q[11:7];
  assign i_imm = {{(core_pkg::xlen-12){inst_q[31]}}, inst_q[31:20]};
  assign u_imm = {inst_q[31:12], 12'b0};

  always_comb begin
    legal = 1'b0;
    alu_op = core_pkg::alu_add;
    use_imm = 1'b0;
    use_pc = 1'b0;
    is_u_type = 1'b0;
    case (opcode)
      core_pkg::op_imm: begin
        use_imm = 1'b1;
        alu_op = funct3_op(funct3, funct3 == 3'b101 && funct7 == core_pkg::funct7_alt);
        // only the shifts constrain the upper immediate bits
        case (funct3)
          3'b001: legal = funct7 == core_pkg::funct7_base;
          3'b101: legal = funct7 == core_pkg::funct7_base || funct7 == core_pkg::funct7_alt;
          default: legal = 1'b1;
        endcase
      end
      core_pkg::op_reg: begin
        alu_op = funct3_op(funct3, funct7 == core_pkg::funct7_alt);
        legal = funct7 == core_pkg::funct7_base
             || (funct7 == core_pkg::funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      core_pkg::lui: begin
        legal = 1'b1;
        alu_op = core_pkg::alu_pass_b;
        use_imm = 1'b1;
        is_u_type = 1'b1;
      end
      core_pkg::auipc: begin
        legal = 1'b1;
        use_imm = 1'b1;
        use_pc = 1'b1;
        is_u_type = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  // u-type reads x0 so lui sees a zero first operand
  assign rs1 = (opcode == core_pkg::op_imm || opcode == core_pkg::op_reg) ? inst_q[19:15] : '0;
  assign rs2 = (opcode == core_pkg::op_reg) ? inst_q[24:20] : '0;

  assign fwd_a = fwd_select(rs1, exec_rd, exec_wen, retire_wen, retire_rd);
  assign fwd_b = fwd_select(rs2, exec_rd, exec_wen, retire_wen, retire_rd);

  assign dec_valid = valid_q;
  assign dec_pc = pc_q;
  assign dec_illegal = valid_q && !legal;
  assign dec_wen = valid_q && legal && rd_field != '0;
  assign dec_rd = legal ? rd_field : '0;
  assign dec_imm = is_u_type ? u_imm : i_imm;
  assign dec_alu_op = alu_op;
  assign dec_use_imm = use_imm;
  assign dec_use_pc = use_pc;

  // a stalled decode slot keeps its instruction
  decode_held_under_stall: assert property (
    @(posedge clock) disable iff (reset || flush)
    stall |=> $stable(dec_valid) && $stable(dec_pc) && $stable(dec_rd)
      && $stable(dec_imm) && $stable(dec_illegal)
  );

endmodule

// ==== verilog/int_pipe_top.sv ====
module int_pipe_top (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic in_valid,
  output logic in_ready,
  input  logic [core_pkg::xlen-1:0] in_pc,
  input  logic [core_pkg::xlen-1:0] in_inst,
  output logic retire_valid,
  input  logic retire_ready,
  output logic [core_pkg::xlen-1:0] retire_pc,
  output logic [core_pkg::reg_addr_width-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0] retire_value,
  output logic retire_illegal
);

  logic [core_pkg::reg_addr_width-1:0] rs1;
  logic [core_pkg::reg_addr_width-1:0] rs2;
  logic [core_pkg::xlen-1:0] rdata1;
  logic [core_pkg::xlen-1:0] rdata2;
  logic dec_valid;
  logic dec_wen;
  logic dec_illegal;
  logic dec_use_imm;
  logic dec_use_pc;
  logic [core_pkg::xlen-1:0] dec_pc;
  logic [core_pkg::xlen-1:0] dec_imm;
  logic [core_pkg::reg_addr_width-1:0] dec_rd;
  core_pkg::alu_op_e dec_alu_op;
  core_pkg::fwd_sel_e fwd_a;
  core_pkg::fwd_sel_e fwd_b;
  logic [core_pkg::reg_addr_width-1:0] exec_rd;
  logic exec_wen;
  logic retire_wen;
  logic stall;
  logic wr_en;
  logic [core_pkg::reg_addr_width-1:0] wr_addr;
  logic [core_pkg::xlen-1:0] wr_data;

  // port names line up across the three blocks
  inst_decoder u_decoder (.*);

  register_file u_register_file (.*);

  alu_stage u_alu_stage (.*);

endmodule

// ==== verilog/register_file.sv ====
module register_file (
  input  logic clock,
  input  logic [core_pkg::reg_addr_width-1:0] rs1,
  input  logic [core_pkg::reg_addr_width-1:0] rs2,
  output logic [core_pkg::xlen-1:0] rdata1,
  output logic [core_pkg::xlen-1:0] rdata2,
  input  logic wr_en,
  input  logic [core_pkg::reg_addr_width-1:0] wr_addr,
  input  logic [core_pkg::xlen-1:0] wr_data
);

  // x0 has no storage
  logic [core_pkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

  // the retire stage must already have dropped writes to x0
  no_write_to_x0: assert property (
    @(posedge clock) wr_en |-> wr_addr != '0
  );

endmodule
